//--- hw/i2s_rx_config.svh
`ifndef I2S_RX_CONFIG_SVH
`define I2S_RX_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// I2S receive path build constants
////////////////////////////////////////////////////////////////////////////

// Bits kept per channel sample
`define I2S_SAMPLE_WIDTH 16

// Stereo frames held in the frame FIFO
`define I2S_FIFO_DEPTH 8

// Frames the sink accepts before it must return credit
`define I2S_SINK_CREDITS 4

// Flip-flops per pin synchronizer
`define I2S_SYNC_STAGES 2

`endif

//--- hw/i2s_types_pkg.sv
`include "i2s_rx_config.svh"

////////////////////////////////////////////////////////////////////////////
// Audio data types
////////////////////////////////////////////////////////////////////////////

package i2s_types_pkg;

	// One channel sample as received MSB first
	typedef logic [`I2S_SAMPLE_WIDTH-1:0] sample_t;

	// Channel follows ws, low selects left
	typedef enum logic
	{
		CHAN_LEFT  = 1'b0,
		CHAN_RIGHT = 1'b1
	} chan_t;

endpackage

//--- hw/i2s_ctrl_pkg.sv
`include "i2s_rx_config.svh"

package i2s_ctrl_pkg;

	// Receiver enable sequence
	typedef enum logic [1:0]
	{
		RX_IDLE   = 2'd0,
		RX_ARM    = 2'd1,
		RX_ACTIVE = 2'd2
	} rx_state_t;

	// Holds 0 up to the full sink credit
	typedef logic [$clog2(`I2S_SINK_CREDITS + 1)-1:0] credit_t;

endpackage

//--- hw/i2s_line_sync.sv
`timescale 1ns/100ps
`include "i2s_rx_config.svh"

module i2s_line_sync
(
	input  logic clk,
	input  logic rst,
	input  logic sck,
	input  logic ws,
	input  logic sd,
	output logic bit_strobe,
	output logic bit_ws,
	output logic bit_sd
);

	localparam int STAGES = `I2S_SYNC_STAGES;

	// Synchronizer chains, the top bit is the settled value
	logic [STAGES-1:0] sck_sync;
	logic [STAGES-1:0] ws_sync;
	logic [STAGES-1:0] sd_sync;
	// Last settled sck level for edge detection
	logic              sck_prev;
	logic              sck_rise;

	// ws and sd go through the same depth as sck so all three stay aligned
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sck_sync <= '0;
			ws_sync  <= '0;
			sd_sync  <= '0;
			sck_prev <= 1'b0;
		end
		else
		begin
			sck_sync <= {sck_sync[STAGES-2:0], sck};
			ws_sync  <= {ws_sync[STAGES-2:0], ws};
			sd_sync  <= {sd_sync[STAGES-2:0], sd};
			sck_prev <= sck_sync[STAGES-1];
		end
	end

	assign sck_rise = sck_sync[STAGES-1] & ~sck_prev;

	// Edge register, strobe lands one cycle after the chain settles
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			bit_strobe <= 1'b0;
		else
			bit_strobe <= sck_rise;
	end

	// Line values captured on the same sck edge, held between strobes
	always_ff @(posedge clk)
	begin
		if (sck_rise)
		begin
			bit_ws <= ws_sync[STAGES-1];
			bit_sd <= sd_sync[STAGES-1];
		end
	end

	// An sck edge can never repeat on consecutive clk cycles
	a_strobe_single: assert property (@(posedge clk) disable iff (!rst)
		bit_strobe |=> !bit_strobe);

endmodule

//--- hw/i2s_slot_deserializer.sv
`timescale 1ns/100ps

module i2s_slot_deserializer
	import i2s_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    bit_strobe,
	input  logic    bit_ws,
	input  logic    bit_sd,
	output logic    word_valid,
	output chan_t   word_chan,
	output sample_t word_data
);

	localparam int W = $bits(sample_t);

	// ws seen at the previous strobe, owns the bit arriving now
	logic    prev_ws;
	// Set once a previous ws is known
	logic    primed;
	// Bits of the running slot, MSB first
	sample_t shreg;
	sample_t shifted;
	logic    slot_end;

	assign shifted  = {shreg[W-2:0], bit_sd};
	// ws leads data by one bit, so a ws change marks the slot's LSB
	assign slot_end = bit_strobe && primed && (bit_ws != prev_ws);

	// Control flags
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			prev_ws    <= 1'b0;
			primed     <= 1'b0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= slot_end;
			if (bit_strobe)
			begin
				prev_ws <= bit_ws;
				primed  <= 1'b1;
			end
		end
	end

	// Shift path and word capture
	always_ff @(posedge clk)
	begin
		if (bit_strobe)
		begin
			if (slot_end)
			begin
				word_data <= shifted;
				word_chan <= chan_t'(prev_ws);
				// New slot starts from a clean register
				shreg     <= '0;
			end
			else
				shreg <= shifted;
		end
	end

endmodule

//--- hw/frame_fifo.sv
`timescale 1ns/100ps

module frame_fifo
#(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
)
(
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	// Frames currently stored
	logic [CW-1:0]    count;
	logic             do_push;
	logic             do_pop;

	assign full    = (count == CW'(DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) pop |-> !empty);

endmodule

//--- hw/i2s_rx_ctrl.sv
`timescale 1ns/100ps
`include "i2s_rx_config.svh"

module i2s_rx_ctrl
	import i2s_types_pkg::*;
	import i2s_ctrl_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          rx_enable,
	input  logic                          word_valid,
	input  chan_t                         word_chan,
	input  sample_t                       word_data,
	input  logic                          credit_return,
	input  logic                          full,
	input  logic                          empty,
	input  logic [2*$bits(sample_t)-1:0] pop_data,
	output logic                          push,
	output logic [2*$bits(sample_t)-1:0] push_data,
	output logic                          pop,
	output logic                          frame_valid,
	output sample_t                       frame_left,
	output sample_t                       frame_right,
	output logic                          overrun
);

	rx_state_t state;
	credit_t   credit;
	// Left word waiting for its right partner
	sample_t   left_hold;
	logic      left_valid;
	logic      frame_done;

	////////////////////////////////////////////////////////////////////////////
	// Enable sequence and pairing
	////////////////////////////////////////////////////////////////////////////

	// Right word with a held left word closes a stereo frame
	assign frame_done = rx_enable && (state == RX_ACTIVE) && word_valid &&
		(word_chan == CHAN_RIGHT) && left_valid;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= RX_IDLE;
		else if (!rx_enable)
			state <= RX_IDLE;
		else
		begin
			case (state)
				RX_IDLE: state <= RX_ARM;
				// Arming right word is dropped, next left starts a frame
				RX_ARM:
				begin
					if (word_valid && word_chan == CHAN_RIGHT)
						state <= RX_ACTIVE;
				end
				RX_ACTIVE: state <= RX_ACTIVE;
				default:   state <= RX_IDLE;
			endcase
		end
	end

	// Left hold flag, cleared by a completed pair or a disable
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			left_valid <= 1'b0;
		else if (!rx_enable)
			left_valid <= 1'b0;
		else if (state == RX_ACTIVE && word_valid)
			left_valid <= (word_chan == CHAN_LEFT);
	end

	always_ff @(posedge clk)
	begin
		if (state == RX_ACTIVE && word_valid && word_chan == CHAN_LEFT)
			left_hold <= word_data;
		if (frame_done)
			push_data <= {left_hold, word_data};
	end

	// Push one cycle after the pair closes, drop and flag when full
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			push    <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			push <= frame_done && !full;
			if (!rx_enable)
				overrun <= 1'b0;
			else if (frame_done && full)
				overrun <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Credit flow toward the sink
	////////////////////////////////////////////////////////////////////////////

	// Pop only with a frame buffered and a credit in hand
	assign pop = (credit != '0) && !empty;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			credit      <= credit_t'(`I2S_SINK_CREDITS);
			frame_valid <= 1'b0;
		end
		else
		begin
			// FIFO read data is valid the cycle after pop
			frame_valid <= pop;
			case ({pop, credit_return})
				2'b10:   credit <= credit - 1'b1;
				2'b01:   credit <= credit + 1'b1;
				default: credit <= credit;
			endcase
		end
	end

	assign {frame_left, frame_right} = pop_data;

	// Sink must never hand back more credit than it took
	a_credit_max: assert property (@(posedge clk) disable iff (!rst)
		credit <= credit_t'(`I2S_SINK_CREDITS));

endmodule

//--- hw/i2s_rx_top.sv
`timescale 1ns/100ps
`include "i2s_rx_config.svh"

module i2s_rx_top
	import i2s_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    sck,
	input  logic    ws,
	input  logic    sd,
	input  logic    rx_enable,
	input  logic    credit_return,
	output logic    frame_valid,
	output sample_t frame_left,
	output sample_t frame_right,
	output logic    overrun
);

	localparam int FRAME_W = 2 * `I2S_SAMPLE_WIDTH;

	// Synchronized bit stream
	logic               bit_strobe;
	logic               bit_ws;
	logic               bit_sd;
	// Completed channel words
	logic               word_valid;
	chan_t              word_chan;
	sample_t            word_data;
	// Frame FIFO handshake
	logic               push;
	logic [FRAME_W-1:0] push_data;
	logic               pop;
	logic [FRAME_W-1:0] pop_data;
	logic               full;
	logic               empty;

	i2s_line_sync u_line_sync
	(
		.clk        (clk),
		.rst        (rst),
		.sck        (sck),
		.ws         (ws),
		.sd         (sd),
		.bit_strobe (bit_strobe),
		.bit_ws     (bit_ws),
		.bit_sd     (bit_sd)
	);

	i2s_slot_deserializer u_deser
	(
		.clk        (clk),
		.rst        (rst),
		.bit_strobe (bit_strobe),
		.bit_ws     (bit_ws),
		.bit_sd     (bit_sd),
		.word_valid (word_valid),
		.word_chan  (word_chan),
		.word_data  (word_data)
	);

	i2s_rx_ctrl u_ctrl
	(
		.clk           (clk),
		.rst           (rst),
		.rx_enable     (rx_enable),
		.word_valid    (word_valid),
		.word_chan     (word_chan),
		.word_data     (word_data),
		.credit_return (credit_return),
		.full          (full),
		.empty         (empty),
		.pop_data      (pop_data),
		.push          (push),
		.push_data     (push_data),
		.pop           (pop),
		.frame_valid   (frame_valid),
		.frame_left    (frame_left),
		.frame_right   (frame_right),
		.overrun       (overrun)
	);

	// Left sample in the upper half of each entry
	frame_fifo #(.WIDTH(FRAME_W), .DEPTH(`I2S_FIFO_DEPTH)) u_fifo
	(
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_data (push_data),
		.pop       (pop),
		.pop_data  (pop_data),
		.full      (full),
		.empty     (empty)
	);

endmodule

//--- tests/i2s_bus_driver.svh
`ifndef I2S_BUS_DRIVER_SVH
`define I2S_BUS_DRIVER_SVH

////////////////////////////////////////////////////////////////////////////
// I2S master model, bit-banged on the falling clk edge
////////////////////////////////////////////////////////////////////////////

// One serial bit, 8 clk long
// sck low for the first half while ws and sd settle, high for the second
task automatic drive_bit(input logic ws_val, input logic sd_val);
	@(negedge clk);
	sck = 1'b0;
	ws  = ws_val;
	sd  = sd_val;
	repeat (4) @(negedge clk);
	// Receiver samples on this rising edge
	sck = 1'b1;
	repeat (3) @(negedge clk);
endtask

// One stereo frame, left slot then right slot, MSB first
task automatic send_frame(input sample_t left, input sample_t right);
	localparam int W = `I2S_SAMPLE_WIDTH;
	logic [2*W-1:0] bits;
	logic           ws_bit;
	bits = {left, right};
	for (int i = 0; i < 2 * W; i++)
	begin
		// ws flips on the LSB of each slot, one bit ahead of the next MSB
		ws_bit = (i >= W - 1) && (i < 2 * W - 1);
		drive_bit(ws_bit, bits[2*W-1-i]);
	end
endtask

`endif

//--- tests/tb_i2s_rx.sv
`timescale 1ns/100ps
`include "i2s_rx_config.svh"

module tb_i2s_rx
	import i2s_types_pkg::*;
();

	localparam int WAIT_LIMIT = 4000;

	logic    clk;
	logic    rst;
	logic    sck;
	logic    ws;
	logic    sd;
	logic    rx_enable;
	logic    credit_return;
	logic    frame_valid;
	sample_t frame_left;
	sample_t frame_right;
	logic    overrun;

	// Scoreboard with the left sample in the upper half
	logic [2*`I2S_SAMPLE_WIDTH-1:0] expected_q [$];
	int received;
	// Credits taken by delivered frames and not yet handed back
	int credit_owed;
	logic sink_on;
	int error_count;
	int timeout_count;

	always #2 clk = ~clk;

	i2s_rx_top dut
	(
		.clk           (clk),
		.rst           (rst),
		.sck           (sck),
		.ws            (ws),
		.sd            (sd),
		.rx_enable     (rx_enable),
		.credit_return (credit_return),
		.frame_valid   (frame_valid),
		.frame_left    (frame_left),
		.frame_right   (frame_right),
		.overrun       (overrun)
	);

	`include "i2s_bus_driver.svh"

	////////////////////////////////////////////////////////////////////////////
	// Sink side sampled on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic check_frame();
		logic [2*`I2S_SAMPLE_WIDTH-1:0] want;
		assert (expected_q.size() != 0)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: unexpected frame %h/%h", $time,
				frame_left, frame_right);
		end
		if (expected_q.size() != 0)
		begin
			want = expected_q.pop_front();
			assert ({frame_left, frame_right} == want)
			else
			begin
				error_count++;
				$display("[ERROR] %0t: frame %h/%h, expected %h", $time,
					frame_left, frame_right, want);
			end
		end
		received++;
		credit_owed++;
	endtask

	// One credit per cycle and never more than were taken
	task automatic return_credit();
		if (sink_on && credit_owed > 0)
		begin
			credit_return = 1'b1;
			credit_owed--;
		end
		else
			credit_return = 1'b0;
	endtask

	always @(negedge clk)
	begin
		if (frame_valid)
			check_frame();
		return_credit();
	end

	function automatic sample_t random_sample();
		return sample_t'($urandom);
	endfunction

	task automatic send_expected(input sample_t left, input sample_t right);
		expected_q.push_back({left, right});
		send_frame(left, right);
	endtask

	// Fresh arm followed by the arming pair whose right word is discarded
	task automatic arm_receiver();
		@(negedge clk);
		rx_enable = 1'b0;
		@(negedge clk);
		rx_enable = 1'b1;
		send_frame(random_sample(), random_sample());
	endtask

	// Scoreboard counters move on the falling edge and are polled on the rising one
	task automatic wait_drained(input string what);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (expected_q.size() != 0 && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (expected_q.size() != 0)
		begin
			timeout_count++;
			$display("Timed out at %0t with %0d %s frames never delivered", $time,
				expected_q.size(), what);
		end
	endtask

	// DUT holds its full credit again once the sink owes nothing
	task automatic wait_credits_returned();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (credit_owed != 0 && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (credit_owed != 0)
		begin
			timeout_count++;
			$display("Timed out at %0t with %0d credits still held by the sink", $time,
				credit_owed);
		end
	endtask

	task automatic wait_received(input int target);
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (received < target && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (received < target)
		begin
			timeout_count++;
			$display("Timed out at %0t after %0d of %0d frames", $time,
				received, target);
		end
	endtask

	task automatic wait_overrun();
		int cycles;
		cycles = 0;
		while (!overrun && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!overrun)
		begin
			timeout_count++;
			$display("Timed out at %0t waiting for the overrun flag", $time);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_stream();
		assert (!frame_valid && !overrun)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: frame_valid or overrun high after reset", $time);
		end
		arm_receiver();
		repeat (20)
			send_expected(random_sample(), random_sample());
		wait_drained("streamed");
	endtask

	task automatic test_disabled();
		int start;
		@(negedge clk);
		rx_enable = 1'b0;
		start = received;
		repeat (3)
			send_frame(random_sample(), random_sample());
		repeat (40) @(posedge clk);
		assert (received == start)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: %0d frames delivered while disabled", $time,
				received - start);
		end
		// Arming pair must not show up
		arm_receiver();
		repeat (3)
			send_expected(random_sample(), random_sample());
		wait_drained("post-enable");
	endtask

	task automatic test_backpressure();
		int start;
		wait_credits_returned();
		sink_on = 1'b0;
		arm_receiver();
		start = received;
		repeat (6)
			send_expected(random_sample(), random_sample());
		wait_received(start + `I2S_SINK_CREDITS);
		repeat (40) @(posedge clk);
		assert (received == start + `I2S_SINK_CREDITS)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: %0d frames without credit, expected %0d", $time,
				received - start, `I2S_SINK_CREDITS);
		end
		sink_on = 1'b1;
		wait_drained("buffered");
	endtask

	task automatic test_overrun();
		int start;
		sample_t left;
		sample_t right;
		wait_credits_returned();
		sink_on = 1'b0;
		arm_receiver();
		start = received;
		// Only credits plus FIFO depth get through
		for (int i = 0; i < 14; i++)
		begin
			left  = random_sample();
			right = random_sample();
			if (i < `I2S_SINK_CREDITS + `I2S_FIFO_DEPTH)
				expected_q.push_back({left, right});
			send_frame(left, right);
		end
		wait_overrun();
		@(posedge clk);
		assert (received == start + `I2S_SINK_CREDITS)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: %0d frames without credit during overrun", $time,
				received - start);
		end
		sink_on = 1'b1;
		wait_drained("pre-overrun");
		@(negedge clk);
		assert (overrun)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: overrun cleared while still enabled", $time);
		end
		rx_enable = 1'b0;
		@(negedge clk);
		assert (!overrun)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: overrun still high after disable", $time);
		end
	endtask

	task automatic test_mid_slot_drop();
		int start;
		arm_receiver();
		start = received;
		// Disable lands 8 bits into the right slot
		fork
			send_frame(random_sample(), random_sample());
			begin
				repeat (24 * 8) @(negedge clk);
				rx_enable = 1'b0;
			end
		join
		repeat (40) @(posedge clk);
		assert (received == start)
		else
		begin
			error_count++;
			$display("[ERROR] %0t: frame delivered from a broken pair", $time);
		end
		arm_receiver();
		repeat (3)
			send_expected(random_sample(), random_sample());
		wait_drained("re-armed");
	endtask

	initial
	begin
		void'($urandom(32'h51911e8c));
		clk           = 1'b0;
		rst           = 1'b0;
		sck           = 1'b0;
		ws            = 1'b0;
		sd            = 1'b0;
		rx_enable     = 1'b0;
		credit_return = 1'b0;
		received      = 0;
		credit_owed   = 0;
		sink_on       = 1'b1;
		error_count   = 0;
		timeout_count = 0;
		repeat (3) @(negedge clk);
		rst = 1'b1;

		test_stream();
		test_disabled();
		test_backpressure();
		test_overrun();
		test_mid_slot_drop();

		$display("Done: %0d errors, %0d timeouts, %0d frames received",
			error_count, timeout_count, received);
		if (error_count == 0 && timeout_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hw
+incdir+tests
hw/i2s_types_pkg.sv
hw/i2s_ctrl_pkg.sv
hw/i2s_line_sync.sv
hw/i2s_slot_deserializer.sv
hw/frame_fifo.sv
hw/i2s_rx_ctrl.sv
hw/i2s_rx_top.sv
tests/tb_i2s_rx.sv
